//--- sources.f
+incdir+.
xt_chipset_pkg.sv
io_address_decoder.sv
ems_page_mapper.sv
io_port_registers.sv
timer_clock_generator.sv
chipset_read_mux.sv
xt_chipset_top.sv
tb_xt_chipset.sv

//--- tb_xt_chipset.sv
/*
 * Testbench for the PC/XT chipset glue logic
 * Reference model of decode, EMS, port latches and timer clock
 */
`include "xt_chipset_defs.svh"

module tb_xt_chipset;
    timeunit 1ns;
    timeprecision 1ps;
    import xt_chipset_pkg::*;

    localparam int READ_TIMEOUT = 8;

    logic clock, reset, io_read_n_i, io_write_n_i, address_enable_n_i;
    logic tandy_video_i, ems_enabled_i, peripheral_clock_i;
    logic [`XT_ADDR_W-1:0] address_i;
    logic [`XT_DATA_W-1:0] data_i;
    logic [1:0] ems_base_i;
    logic dma_cs_n_o, pic_cs_n_o, pit_cs_n_o, ppi_cs_n_o, dma_page_cs_n_o;
    logic [`EMS_PAGES-1:0] ems_bank_o;
    logic [`XT_DATA_W-1:0] data_o;
    logic data_valid_o, timer_clock_o;

    integer seed = 32'he81eca7a;
    int errors = 0;
    logic [31:0] rnd;
    logic [`XT_DATA_W-1:0] expected_q[$];
    logic [`EMS_MAP_W-1:0] ref_map[`EMS_PAGES];
    logic ref_en[`EMS_PAGES];
    logic [`XT_DATA_W-1:0] ref_lpt, ref_nmi;

    xt_chipset_top xt_chipset_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", what);
    endtask

    function automatic logic [4:0] expected_cs_n(logic [19:0] addr, logic rd_n, logic wr_n,
                                                 logic aen_n);
        logic [4:0] sel;
        sel = '0;
        if (!aen_n && (!rd_n || !wr_n) && addr[9:8] == 2'b00 && addr[7:5] < 3'd5) begin
            sel[3'd4 - addr[7:5]] = 1'b1;
        end
        return ~sel;
    endfunction

    function automatic ems_cmd_e ems_decode(logic [7:0] data);
        if (data == 8'hFF) return EMS_DISABLE;
        else if (data < 8'h80) return EMS_MAP;
        else return EMS_KEEP;
    endfunction

    function automatic logic [7:0] ems_expected(int page);
        return ref_en[page] ? {1'b0, ref_map[page]} : 8'hFF;
    endfunction

    function automatic logic [3:0] expected_banks(logic [19:0] addr, logic [1:0] base);
        logic [3:0] nibble;
        logic [3:0] hits;
        nibble = (base == 2'd0) ? 4'hA : (base == 2'd1) ? 4'hC : 4'hD;
        for (int p = 0; p < 4; p++) begin
            hits[p] = ref_en[p] && (addr[19:14] == {nibble, 2'(p)});
        end
        return hits;
    endfunction

    // Every valid read must match the oldest expected value
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && data_valid_o) begin
                if (expected_q.size() == 0) begin
                    abort_run("data_valid_o went high without a pending chipset read");
                end else begin
                    check_value("data_o", data_o, expected_q.pop_front());
                end
            end else if (!reset) begin
                check_value("data_o while idle", data_o, 0);
            end
        end
    end

    task automatic io_write(input logic [19:0] addr, input logic [7:0] data);
        address_i = addr;
        data_i = data;
        io_write_n_i = 1'b0;
        @(negedge clock);
        io_write_n_i = 1'b1;
    endtask

    task automatic io_read(input logic [19:0] addr, input logic expect_valid,
                           input logic [7:0] expected);
        int waited;
        waited = 0;
        if (expect_valid) expected_q.push_back(expected);
        address_i = addr;
        io_read_n_i = 1'b0;
        @(negedge clock);
        io_read_n_i = 1'b1;
        while (expected_q.size() != 0) begin
            if (waited == READ_TIMEOUT) begin
                abort_run("read data never came back on data_o");
            end else begin
                @(negedge clock);
                waited++;
            end
        end
        @(negedge clock);
    endtask

    task automatic ems_write(input int page, input logic [7:0] data);
        io_write(20'(`EMS_PORT_BASE) + 20'(page), data);
        case (ems_decode(data))
            EMS_DISABLE: begin
                ref_map[page] = 7'h7F;
                ref_en[page] = 1'b0;
            end
            EMS_MAP: begin
                ref_map[page] = data[6:0];
                ref_en[page] = 1'b1;
            end
            default: ;
        endcase
        repeat (2) @(negedge clock);
    endtask

    task automatic decode_check(input logic [19:0] addr, input logic rd_n, input logic wr_n,
                                input logic aen_n);
        address_i = addr;
        io_read_n_i = rd_n;
        io_write_n_i = wr_n;
        address_enable_n_i = aen_n;
        #1;
        check_value("chip selects", {dma_cs_n_o, pic_cs_n_o, pit_cs_n_o, ppi_cs_n_o,
                    dma_page_cs_n_o}, expected_cs_n(addr, rd_n, wr_n, aen_n));
        if (rd_n && wr_n) check_value("ems_bank_o", ems_bank_o, expected_banks(addr, ems_base_i));
        @(negedge clock);
        io_read_n_i = 1'b1;
        io_write_n_i = 1'b1;
        address_enable_n_i = 1'b0;
    endtask

    initial begin
        int toggles;
        logic last_timer;
        reset = 1'b1;
        io_read_n_i = 1'b1;
        io_write_n_i = 1'b1;
        address_enable_n_i = 1'b0;
        tandy_video_i = 1'b0;
        ems_enabled_i = 1'b0;
        peripheral_clock_i = 1'b0;
        address_i = '0;
        data_i = '0;
        ems_base_i = 2'd0;
        for (int p = 0; p < 4; p++) begin
            ref_map[p] = '0;
            ref_en[p] = 1'b0;
        end
        ref_lpt = 8'hFF;
        ref_nmi = 8'hFF;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        check_value("timer_clock_o", timer_clock_o, 0);
        check_value("data_valid_o", data_valid_o, 0);

        // Reset values read first with the EMS port off
        io_read(20'h00260, 1'b0, 8'h00);
        ems_enabled_i = 1'b1;
        tandy_video_i = 1'b1;
        for (int p = 0; p < 4; p++) io_read(20'h00260 + 20'(p), 1'b1, ems_expected(p));
        io_read(20'h00378, 1'b1, ref_lpt);
        io_read(20'h000A0, 1'b1, ref_nmi);

        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            decode_check(20'(rnd[15:0] % 16'hA0), rnd[20], ~rnd[20], 1'b0);
        end
        decode_check(20'h00020, 1'b1, 1'b1, 1'b0);
        decode_check(20'h00040, 1'b0, 1'b1, 1'b1);

        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            case (rnd[9:8])
                2'd0: data_i = {1'b0, rnd[6:0]};
                2'd1: data_i = 8'hFF;
                default: data_i = 8'h80 + 8'(rnd[15:10] + rnd[21:16]);
            endcase
            ems_write(rnd[23:22], data_i);
            io_read(20'h00260 + 20'(rnd[23:22]), 1'b1, ems_expected(rnd[23:22]));
        end

        ems_write(0, 8'h05);
        ems_write(1, 8'h7F);
        ems_write(2, 8'hFF);
        ems_write(3, 8'h2A);
        for (int b = 0; b < 4; b++) begin
            ems_base_i = 2'(b);
            for (int p = 0; p < 4; p++) begin
                rnd = $random(seed);
                decode_check({(b == 0) ? 4'hA : (b == 1) ? 4'hC : 4'hD, 2'(p), rnd[13:0]},
                             1'b1, 1'b1, 1'b0);
                rnd = $random(seed);
                decode_check(rnd[19:0], 1'b1, 1'b1, 1'b0);
            end
        end

        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            io_write(20'h00378, rnd[7:0]);
            ref_lpt = rnd[7:0];
            io_read(20'h00378, 1'b1, ref_lpt);
            io_write(20'h000A0 + 20'(rnd[10:8]), rnd[23:16]);
            ref_nmi = rnd[23:16];
            io_read(20'h000A0 + 20'(rnd[13:11]), 1'b1, ref_nmi);
        end
        tandy_video_i = 1'b0;
        io_write(20'h000A3, 8'h5C);
        io_read(20'h000A3, 1'b0, 8'h00);
        tandy_video_i = 1'b1;
        io_read(20'h000A3, 1'b1, ref_nmi);

        // Peripheral clock at eight system clocks per period
        toggles = 0;
        last_timer = timer_clock_o;
        for (int c = 0; c < 20 * 8 + 4; c++) begin
            peripheral_clock_i = (c < 160) && (c % 8 < 4);
            @(negedge clock);
            if (timer_clock_o != last_timer) toggles++;
            last_timer = timer_clock_o;
        end
        if (toggles < 19 || toggles > 21) begin
            check_value("timer_clock_o toggles", toggles, 20);
        end

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- xt_chipset_top.sv
/*
 * PC/XT chipset glue logic, top level
 * Address decode, EMS mapper, port latches, read mux and timer clock
 */
`include "xt_chipset_defs.svh"

module xt_chipset_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`XT_ADDR_W-1:0] address_i,
    input  logic [`XT_DATA_W-1:0] data_i,
    input  logic                  io_read_n_i,
    input  logic                  io_write_n_i,
    input  logic                  address_enable_n_i,
    input  logic                  tandy_video_i,
    input  logic                  ems_enabled_i,
    input  logic [1:0]            ems_base_i,
    input  logic                  peripheral_clock_i,
    output logic                  dma_cs_n_o,
    output logic                  pic_cs_n_o,
    output logic                  pit_cs_n_o,
    output logic                  ppi_cs_n_o,
    output logic                  dma_page_cs_n_o,
    output logic [`EMS_PAGES-1:0] ems_bank_o,
    output logic [`XT_DATA_W-1:0] data_o,
    output logic                  data_valid_o,
    output logic                  timer_clock_o
);
    import xt_chipset_pkg::*;

    bus_cycle_t            bus;
    chip_select_t          sel;
    logic [`EMS_PAGES-1:0] page_enable;
    logic [`XT_DATA_W-1:0] ems_read;
    logic [`XT_DATA_W-1:0] lpt_data;
    logic [`XT_DATA_W-1:0] nmi_mask;

    assign bus.address          = address_i;
    assign bus.wdata            = data_i;
    assign bus.io_read_n        = io_read_n_i;
    assign bus.io_write_n       = io_write_n_i;
    // No I/O strobe means a memory cycle
    assign bus.memory_cycle     = io_read_n_i & io_write_n_i;
    assign bus.address_enable_n = address_enable_n_i;

    // External chips take active-low selects
    assign dma_cs_n_o      = ~sel.dma;
    assign pic_cs_n_o      = ~sel.pic;
    assign pit_cs_n_o      = ~sel.pit;
    assign ppi_cs_n_o      = ~sel.ppi;
    assign dma_page_cs_n_o = ~sel.dma_page;

    io_address_decoder io_address_decoder_i (
        .bus_i         (bus),
        .tandy_video_i (tandy_video_i),
        .ems_enabled_i (ems_enabled_i),
        .ems_base_i    (ems_base_i),
        .page_enable_i (page_enable),
        .sel_o         (sel),
        .ems_bank_o    (ems_bank_o)
    );

    ems_page_mapper ems_page_mapper_i (
        .clock         (clock),
        .reset         (reset),
        .bus_i         (bus),
        .sel_i         (sel),
        .page_enable_o (page_enable),
        .ems_read_o    (ems_read)
    );

    io_port_registers io_port_registers_i (
        .clock      (clock),
        .reset      (reset),
        .bus_i      (bus),
        .sel_i      (sel),
        .lpt_data_o (lpt_data),
        .nmi_mask_o (nmi_mask)
    );

    chipset_read_mux chipset_read_mux_i (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus),
        .sel_i        (sel),
        .ems_read_i   (ems_read),
        .lpt_data_i   (lpt_data),
        .nmi_mask_i   (nmi_mask),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

    timer_clock_generator timer_clock_generator_i (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

endmodule

//--- chipset_read_mux.sv
/*
 * Chipset read-data mux
 * Registers EMS, printer or NMI-mask data onto the CPU data bus
 */
`include "xt_chipset_defs.svh"

module chipset_read_mux (
    input  logic                         clock,
    input  logic                         reset,
    input  xt_chipset_pkg::bus_cycle_t   bus_i,
    input  xt_chipset_pkg::chip_select_t sel_i,
    input  logic [`XT_DATA_W-1:0]        ems_read_i,
    input  logic [`XT_DATA_W-1:0]        lpt_data_i,
    input  logic [`XT_DATA_W-1:0]        nmi_mask_i,
    output logic [`XT_DATA_W-1:0]        data_o,
    output logic                         data_valid_o
);
    import xt_chipset_pkg::*;

    read_src_e src;

    // EMS wins over printer, printer over NMI
    always_comb begin
        src = READ_NONE;
        if (~bus_i.io_read_n) begin
            if (sel_i.ems_port) begin
                src = READ_EMS;
            end else if (sel_i.lpt) begin
                src = READ_LPT;
            end else if (sel_i.nmi_mask) begin
                src = READ_NMI;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= (src != READ_NONE);
            case (src)
                READ_EMS: data_o <= ems_read_i;
                READ_LPT: data_o <= lpt_data_i;
                READ_NMI: data_o <= nmi_mask_i;
                default:  data_o <= '0;
            endcase
        end
    end

    a_valid_after_read: assert property (@(posedge clock) disable iff (reset)
        $rose(data_valid_o) |-> $past(!bus_i.io_read_n));

endmodule

//--- timer_clock_generator.sv
/*
 * Timer clock generator
 * Toggles the 8253 clock on each synchronized rising edge of the peripheral clock
 */
module timer_clock_generator (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);

    // Two synchronizer flops plus one for edge detect
    logic [2:0] sync_q;
    logic       rising;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], peripheral_clock_i};
        end
    end

    assign rising = sync_q[1] & ~sync_q[2];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            timer_clock_o <= 1'b0;
        end else if (rising) begin
            timer_clock_o <= ~timer_clock_o;
        end
    end

endmodule

//--- io_port_registers.sv
/*
 * Chipset port latches
 * Printer data at 378h and Tandy NMI mask at A0h..A7h
 */
`include "xt_chipset_defs.svh"

module io_port_registers (
    input  logic                         clock,
    input  logic                         reset,
    input  xt_chipset_pkg::bus_cycle_t   bus_i,
    input  xt_chipset_pkg::chip_select_t sel_i,
    output logic [`XT_DATA_W-1:0]        lpt_data_o,
    output logic [`XT_DATA_W-1:0]        nmi_mask_o
);

    logic io_write;

    assign io_write = ~bus_i.io_write_n;

    // Printer data latch
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o <= '1;
        end else if (sel_i.lpt && io_write) begin
            lpt_data_o <= bus_i.wdata;
        end
    end

    // NMI mask starts with everything masked
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_o <= '1;
        end else if (sel_i.nmi_mask && io_write) begin
            nmi_mask_o <= bus_i.wdata;
        end
    end

endmodule

//--- ems_page_mapper.sv
/*
 * EMS page mapper
 * Four segment map registers behind ports 260h..263h, two-stage write path
 */
`include "xt_chipset_defs.svh"

module ems_page_mapper (
    input  logic                         clock,
    input  logic                         reset,
    input  xt_chipset_pkg::bus_cycle_t   bus_i,
    input  xt_chipset_pkg::chip_select_t sel_i,
    output logic [`EMS_PAGES-1:0]        page_enable_o,
    output logic [`XT_DATA_W-1:0]        ems_read_o
);
    import xt_chipset_pkg::*;

    logic [`EMS_MAP_W-1:0] map_q [`EMS_PAGES];
    ems_cmd_e              cmd;
    logic                  wr_strobe;
    logic                  wr_pending;
    logic [1:0]            wr_index;
    ems_cmd_e              wr_cmd;
    logic [`EMS_MAP_W-1:0] wr_map;
    logic [1:0]            rd_index;

    assign wr_strobe = sel_i.ems_port & ~bus_i.io_write_n;

    always_comb begin
        if (bus_i.wdata == `EMS_DISABLE_CODE) begin
            cmd = EMS_DISABLE;
        end else if (bus_i.wdata < `EMS_MAP_LIMIT) begin
            cmd = EMS_MAP;
        end else begin
            cmd = EMS_KEEP;
        end
    end

    // Stage 1 captures the write
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= wr_strobe;
        end
    end

    always_ff @(posedge clock) begin
        wr_index <= bus_i.address[1:0];
        wr_cmd   <= cmd;
        wr_map   <= bus_i.wdata[`EMS_MAP_W-1:0];
    end

    // Stage 2 updates the map register
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `EMS_PAGES; i++) begin
                map_q[i] <= '0;
            end
            page_enable_o <= '0;
        end else if (wr_pending) begin
            case (wr_cmd)
                EMS_DISABLE: begin
                    map_q[wr_index]         <= '1;
                    page_enable_o[wr_index] <= 1'b0;
                end
                EMS_MAP: begin
                    map_q[wr_index]         <= wr_map;
                    page_enable_o[wr_index] <= 1'b1;
                end
                default: begin
                    // Out-of-range data leaves the page alone
                end
            endcase
        end
    end

    assign rd_index   = bus_i.address[1:0];
    assign ems_read_o = page_enable_o[rd_index]
                        ? {{(`XT_DATA_W - `EMS_MAP_W){1'b0}}, map_q[rd_index]}
                        : `EMS_DISABLE_CODE;

    a_reset_disables: assert property (@(posedge clock) reset |=> (page_enable_o == '0));

    // Page just disabled reads back FFh
    a_disabled_reads_ff: assert property (@(posedge clock) disable iff (reset)
        (wr_pending && wr_cmd == EMS_DISABLE && rd_index == wr_index) ##1 $stable(rd_index)
        |-> (ems_read_o == `EMS_DISABLE_CODE));

endmodule

//--- io_address_decoder.sv
/*
 * I/O and memory address decoder
 * Low-port chip selects, EMS/printer/NMI port selects and EMS window hits
 */
`include "xt_chipset_defs.svh"

module io_address_decoder (
    input  xt_chipset_pkg::bus_cycle_t   bus_i,
    input  logic                         tandy_video_i,
    input  logic                         ems_enabled_i,
    input  logic [1:0]                   ems_base_i,
    input  logic [`EMS_PAGES-1:0]        page_enable_i,
    output xt_chipset_pkg::chip_select_t sel_o,
    output logic [`EMS_PAGES-1:0]        ems_bank_o
);

    logic       iorq;
    logic       io_cycle;
    logic       low_port;
    logic [2:0] device;
    logic [3:0] ems_nibble;

    assign iorq     = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_cycle = iorq & ~bus_i.address_enable_n;

    // One 32-port block per device in 000h..0FFh
    assign low_port = io_cycle & ~bus_i.address[9] & ~bus_i.address[8];
    assign device   = bus_i.address[7:5];

    always_comb begin
        sel_o.dma      = low_port && (device == 3'd0);
        sel_o.pic      = low_port && (device == 3'd1);
        sel_o.pit      = low_port && (device == 3'd2);
        sel_o.ppi      = low_port && (device == 3'd3);
        sel_o.dma_page = low_port && (device == 3'd4);

        // 260h..263h
        sel_o.ems_port = io_cycle && ems_enabled_i
                         && (bus_i.address[15:2] == `EMS_PORT_BASE >> 2);
        sel_o.lpt      = io_cycle && (bus_i.address[15:0] == `LPT_DATA_PORT);
        // A0h..A7h on Tandy machines only
        sel_o.nmi_mask = io_cycle && tandy_video_i
                         && (bus_i.address[15:3] == `NMI_PORT_BASE >> 3);
    end

    // Window base Ah, Ch or Dh
    always_comb begin
        case (ems_base_i)
            2'd0:    ems_nibble = 4'hA;
            2'd1:    ems_nibble = 4'hC;
            default: ems_nibble = 4'hD;
        endcase
    end

    always_comb begin
        for (int i = 0; i < `EMS_PAGES; i++) begin
            ems_bank_o[i] = bus_i.memory_cycle && page_enable_i[i]
                            && (bus_i.address[`XT_ADDR_W-1 -: 6] == {ems_nibble, 2'(i)});
        end
    end

endmodule

//--- xt_chipset_pkg.sv
/*
 * PC/XT chipset glue types
 * Bus cycle bundle, chip selects and the EMS and read-mux enums
 */
`include "xt_chipset_defs.svh"

package xt_chipset_pkg;

    // One CPU bus cycle as seen by the chipset
    typedef struct packed {
        logic [`XT_ADDR_W-1:0] address;
        logic [`XT_DATA_W-1:0] wdata;
        logic                  io_read_n;
        logic                  io_write_n;
        logic                  memory_cycle;
        logic                  address_enable_n;
    } bus_cycle_t;

    // Active-high selects
    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic ppi;
        logic dma_page;
        logic ems_port;
        logic lpt;
        logic nmi_mask;
    } chip_select_t;

    // Decoded EMS map write
    typedef enum logic [1:0] {
        EMS_DISABLE,
        EMS_MAP,
        EMS_KEEP
    } ems_cmd_e;

    typedef enum logic [1:0] {
        READ_NONE,
        READ_EMS,
        READ_LPT,
        READ_NMI
    } read_src_e;

endpackage

//--- xt_chipset_defs.svh
/*
 * PC/XT chipset glue constants
 * Bus widths, I/O port addresses and EMS data codes
 */
`ifndef XT_CHIPSET_DEFS_SVH
`define XT_CHIPSET_DEFS_SVH

// CPU bus
`define XT_ADDR_W 20
`define XT_DATA_W 8

// Four EMS segment windows of 16 KB each
`define EMS_PAGES 4
`define EMS_MAP_W 7

// I/O ports as seen on address bits 15..0
`define EMS_PORT_BASE 16'h0260
`define LPT_DATA_PORT 16'h0378
`define NMI_PORT_BASE 16'h00A0

// EMS map register write codes
`define EMS_DISABLE_CODE 8'hFF
`define EMS_MAP_LIMIT 8'h80

`endif
